/* source/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    // register and uart byte width
    localparam int DATA_WIDTH = 8;

    // general purpose registers
    localparam int REG_COUNT = 16;

    // program memory words and pc width
    localparam int PROG_DEPTH = 256;
    localparam int PC_WIDTH   = $clog2(PROG_DEPTH);

    // flag register, bit 0 is spare
    localparam int FLAG_COUNT = 4;
    localparam int FLAG_LE    = 1;
    localparam int FLAG_UR    = 2;
    localparam int FLAG_UT    = 3;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int CMD_WIDTH    = 24;
    localparam int OPCODE_WIDTH = 5;

    // field positions inside a command word
    localparam int OPCODE_MSB = 23;
    localparam int OPCODE_LSB = 19;
    localparam int DST_MSB    = 18;
    localparam int DST_LSB    = 15;
    localparam int SRC1_MSB   = 14;
    localparam int SRC1_LSB   = 11;
    localparam int SRC2_MSB   = 10;
    localparam int SRC2_LSB   = 7;
    localparam int LIT_MSB    = 14;
    localparam int LIT_LSB    = 7;
    localparam int LABEL_MSB  = 18;
    localparam int LABEL_LSB  = 11;
    localparam int FLAG_MSB   = 10;
    localparam int FLAG_LSB   = 9;

    // width of a register index field
    localparam int REG_FIELD_WIDTH = DST_MSB - DST_LSB + 1;

    localparam logic [OPCODE_WIDTH-1:0] OP_NOP   = 5'd0;
    localparam logic [OPCODE_WIDTH-1:0] OP_MOV   = 5'd1;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD   = 5'd2;
    localparam logic [OPCODE_WIDTH-1:0] OP_CMP   = 5'd3;
    localparam logic [OPCODE_WIDTH-1:0] OP_INC   = 5'd4;
    localparam logic [OPCODE_WIDTH-1:0] OP_DEC   = 5'd5;
    localparam logic [OPCODE_WIDTH-1:0] OP_JMP   = 5'd6;
    localparam logic [OPCODE_WIDTH-1:0] OP_FJMP  = 5'd7;
    localparam logic [OPCODE_WIDTH-1:0] OP_FNJMP = 5'd8;
    localparam logic [OPCODE_WIDTH-1:0] OP_UGET  = 5'd9;
    localparam logic [OPCODE_WIDTH-1:0] OP_USEND = 5'd10;

endpackage

`default_nettype wire

/* source/program_mem.sv */
`default_nettype none

module program_mem #(
    parameter int PROG_DEPTH = 256
) (
    input  wire                             in_clk,
    input  wire                             in_rst,
    input  wire                             flash_signal,
    input  wire [$clog2(PROG_DEPTH)-1:0]    flash_addr,
    input  wire [isa_pkg::CMD_WIDTH-1:0]    flash_command,
    input  wire [$clog2(PROG_DEPTH)-1:0]    pc,
    output logic [isa_pkg::CMD_WIDTH-1:0]   fetch_command
);

    logic [isa_pkg::CMD_WIDTH-1:0] mem [PROG_DEPTH];

    // flashing ignores en, so a frozen core can be loaded
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < PROG_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (flash_signal) begin
            mem[flash_addr] <= flash_command;
        end
    end

    // async read for the fetch stage
    assign fetch_command = mem[pc];

endmodule

`default_nettype wire

/* source/instr_sequencer.sv */
`default_nettype none

module instr_sequencer #(
    parameter int PROG_DEPTH = 256
) (
    input  wire                                 in_clk,
    input  wire                                 in_rst,
    input  wire                                 en,
    input  wire [isa_pkg::CMD_WIDTH-1:0]        fetch_command,
    input  wire [core_cfg_pkg::FLAG_COUNT-1:0]  flags,
    output logic [$clog2(PROG_DEPTH)-1:0]       pc,
    output logic [isa_pkg::CMD_WIDTH-1:0]       exec_command,
    output logic                                uart_rx_read
);

    localparam logic [isa_pkg::CMD_WIDTH-1:0] NOP_CMD =
        {isa_pkg::OP_NOP, {(isa_pkg::CMD_WIDTH - isa_pkg::OPCODE_WIDTH){1'b0}}};

    logic [isa_pkg::CMD_WIDTH-1:0]    fetch_reg;
    logic [isa_pkg::OPCODE_WIDTH-1:0] op_fetch;
    logic [isa_pkg::OPCODE_WIDTH-1:0] op_exec;
    logic                             ctrl_fetch;
    logic                             ctrl_exec;
    logic                             uart_fetch;
    logic                             flag_bit;
    logic                             taken;
    logic                             stall;

    assign op_fetch = fetch_reg[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB];
    assign op_exec  = exec_command[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB];

    assign ctrl_fetch = (op_fetch == isa_pkg::OP_JMP) ||
                        (op_fetch == isa_pkg::OP_FJMP) ||
                        (op_fetch == isa_pkg::OP_FNJMP);
    assign ctrl_exec  = (op_exec == isa_pkg::OP_JMP) ||
                        (op_exec == isa_pkg::OP_FJMP) ||
                        (op_exec == isa_pkg::OP_FNJMP);
    assign uart_fetch = (op_fetch == isa_pkg::OP_UGET) ||
                        (op_fetch == isa_pkg::OP_USEND);

    // flag picked by the FLAG field of the command in execute
    assign flag_bit = flags[exec_command[isa_pkg::FLAG_MSB:isa_pkg::FLAG_LSB]];

    // branch resolution
    always_comb begin
        case (op_exec)
            isa_pkg::OP_JMP:   taken = 1'b1;
            isa_pkg::OP_FJMP:  taken = flag_bit;
            isa_pkg::OP_FNJMP: taken = ~flag_bit;
            default:           taken = 1'b0;
        endcase
    end

    // jumps in either stage, uart commands in fetch
    assign stall = ctrl_fetch || ctrl_exec || uart_fetch;

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            pc           <= '0;
            fetch_reg    <= '0;
            exec_command <= '0;
        end else if (en) begin
            exec_command <= fetch_reg;
            // bubble while stalled
            fetch_reg    <= stall ? NOP_CMD : fetch_command;
            if (taken) begin
                pc <= exec_command[isa_pkg::LABEL_MSB:isa_pkg::LABEL_LSB];
            end else if (!stall) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // receiver read while UGET sits in fetch
    assign uart_rx_read = en && (op_fetch == isa_pkg::OP_UGET);

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`default_nettype none

module execute_unit #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                                   in_clk,
    input  wire                                   in_rst,
    input  wire                                   en,
    input  wire [isa_pkg::CMD_WIDTH-1:0]          exec_command,
    input  wire [DATA_WIDTH-1:0]                  rd_data_a,
    input  wire [DATA_WIDTH-1:0]                  rd_data_b,
    input  wire [DATA_WIDTH-1:0]                  uart_rx_data,
    input  wire                                   uart_rx_empty,
    input  wire                                   uart_tx_done,
    output logic [isa_pkg::REG_FIELD_WIDTH-1:0]   rd_addr_a,
    output logic [isa_pkg::REG_FIELD_WIDTH-1:0]   rd_addr_b,
    output logic                                  wr_en,
    output logic [isa_pkg::REG_FIELD_WIDTH-1:0]   wr_addr,
    output logic [DATA_WIDTH-1:0]                 wr_data,
    output logic [core_cfg_pkg::FLAG_COUNT-1:0]   flags,
    output logic                                  uart_tx_start,
    output logic [DATA_WIDTH-1:0]                 uart_tx_data
);

    logic [isa_pkg::OPCODE_WIDTH-1:0]    op;
    logic [isa_pkg::REG_FIELD_WIDTH-1:0] dst;
    logic [isa_pkg::REG_FIELD_WIDTH-1:0] src1;
    logic [isa_pkg::REG_FIELD_WIDTH-1:0] src2;
    logic [DATA_WIDTH-1:0]               lit;
    logic                                le_next;
    logic [core_cfg_pkg::FLAG_COUNT-1:0] flags_next;

    assign op   = exec_command[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB];
    assign dst  = exec_command[isa_pkg::DST_MSB:isa_pkg::DST_LSB];
    assign src1 = exec_command[isa_pkg::SRC1_MSB:isa_pkg::SRC1_LSB];
    assign src2 = exec_command[isa_pkg::SRC2_MSB:isa_pkg::SRC2_LSB];
    assign lit  = exec_command[isa_pkg::LIT_MSB:isa_pkg::LIT_LSB];

    // port A carries src1 for two-operand ops, dst otherwise
    always_comb begin
        case (op)
            isa_pkg::OP_ADD, isa_pkg::OP_CMP: rd_addr_a = src1;
            default:                          rd_addr_a = dst;
        endcase
    end

    assign rd_addr_b = src2;
    assign wr_addr   = dst;

    // alu and register write decode, jumps fall to default
    always_comb begin
        wr_en   = 1'b0;
        wr_data = rd_data_a;
        case (op)
            isa_pkg::OP_MOV: begin
                wr_en   = 1'b1;
                wr_data = lit;
            end
            isa_pkg::OP_ADD: begin
                wr_en   = 1'b1;
                wr_data = rd_data_a + rd_data_b;
            end
            isa_pkg::OP_INC: begin
                wr_en   = 1'b1;
                wr_data = rd_data_a + 1'b1;
            end
            isa_pkg::OP_DEC: begin
                wr_en   = 1'b1;
                wr_data = rd_data_a - 1'b1;
            end
            isa_pkg::OP_UGET: begin
                wr_en   = 1'b1;
                wr_data = uart_rx_data;
            end
            default: begin
            end
        endcase
    end

    // LE holds unless an arithmetic op or CMP executes
    always_comb begin
        case (op)
            isa_pkg::OP_ADD, isa_pkg::OP_INC, isa_pkg::OP_DEC: le_next = (wr_data == '0);
            isa_pkg::OP_CMP: le_next = (rd_data_a <= rd_data_b);
            default:         le_next = flags[core_cfg_pkg::FLAG_LE];
        endcase
        flags_next                        = '0;
        flags_next[core_cfg_pkg::FLAG_LE] = le_next;
        flags_next[core_cfg_pkg::FLAG_UR] = ~uart_rx_empty;
        flags_next[core_cfg_pkg::FLAG_UT] = uart_tx_done;
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            flags         <= '0;
            uart_tx_start <= 1'b0;
        end else begin
            // single pulse, never stretched by a frozen core
            uart_tx_start <= en && (op == isa_pkg::OP_USEND);
            if (en) begin
                flags <= flags_next;
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (en && (op == isa_pkg::OP_USEND)) begin
            uart_tx_data <= rd_data_a;
        end
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file #(
    parameter int DATA_WIDTH = 8,
    parameter int REG_COUNT  = 16
) (
    input  wire                           in_clk,
    input  wire                           in_rst,
    input  wire                           en,
    input  wire [$clog2(REG_COUNT)-1:0]   rd_addr_a,
    input  wire [$clog2(REG_COUNT)-1:0]   rd_addr_b,
    input  wire                           wr_en,
    input  wire [$clog2(REG_COUNT)-1:0]   wr_addr,
    input  wire [DATA_WIDTH-1:0]          wr_data,
    output logic [DATA_WIDTH-1:0]         rd_data_a,
    output logic [DATA_WIDTH-1:0]         rd_data_b
);

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (en && wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // both read ports are combinational
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`default_nettype none

module cpu_core (
    input  wire                                   in_clk,
    input  wire                                   in_rst,
    input  wire                                   en,
    input  wire                                   flash_signal,
    input  wire [core_cfg_pkg::PC_WIDTH-1:0]      flash_addr,
    input  wire [isa_pkg::CMD_WIDTH-1:0]          flash_command,
    input  wire                                   uart_rx_empty,
    input  wire [core_cfg_pkg::DATA_WIDTH-1:0]    uart_rx_data,
    input  wire                                   uart_tx_done,
    output logic                                  uart_rx_read,
    output logic                                  uart_tx_start,
    output logic [core_cfg_pkg::DATA_WIDTH-1:0]   uart_tx_data
);

    logic [core_cfg_pkg::PC_WIDTH-1:0]   pc;
    logic [isa_pkg::CMD_WIDTH-1:0]       fetch_command;
    logic [isa_pkg::CMD_WIDTH-1:0]       exec_command;
    logic [core_cfg_pkg::FLAG_COUNT-1:0] flags;
    logic [isa_pkg::REG_FIELD_WIDTH-1:0] rd_addr_a;
    logic [isa_pkg::REG_FIELD_WIDTH-1:0] rd_addr_b;
    logic [core_cfg_pkg::DATA_WIDTH-1:0] rd_data_a;
    logic [core_cfg_pkg::DATA_WIDTH-1:0] rd_data_b;
    logic                                wr_en;
    logic [isa_pkg::REG_FIELD_WIDTH-1:0] wr_addr;
    logic [core_cfg_pkg::DATA_WIDTH-1:0] wr_data;

    program_mem #(
        .PROG_DEPTH    (core_cfg_pkg::PROG_DEPTH)
    ) u_program_mem (
        .in_clk        (in_clk),
        .in_rst        (in_rst),
        .flash_signal  (flash_signal),
        .flash_addr    (flash_addr),
        .flash_command (flash_command),
        .pc            (pc),
        .fetch_command (fetch_command)
    );

    instr_sequencer #(
        .PROG_DEPTH    (core_cfg_pkg::PROG_DEPTH)
    ) u_instr_sequencer (
        .in_clk        (in_clk),
        .in_rst        (in_rst),
        .en            (en),
        .fetch_command (fetch_command),
        .flags         (flags),
        .pc            (pc),
        .exec_command  (exec_command),
        .uart_rx_read  (uart_rx_read)
    );

    execute_unit #(
        .DATA_WIDTH    (core_cfg_pkg::DATA_WIDTH)
    ) u_execute_unit (
        .in_clk        (in_clk),
        .in_rst        (in_rst),
        .en            (en),
        .exec_command  (exec_command),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .uart_rx_data  (uart_rx_data),
        .uart_rx_empty (uart_rx_empty),
        .uart_tx_done  (uart_tx_done),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .flags         (flags),
        .uart_tx_start (uart_tx_start),
        .uart_tx_data  (uart_tx_data)
    );

    reg_file #(
        .DATA_WIDTH    (core_cfg_pkg::DATA_WIDTH),
        .REG_COUNT     (core_cfg_pkg::REG_COUNT)
    ) u_reg_file (
        .in_clk        (in_clk),
        .in_rst        (in_rst),
        .en            (en),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b)
    );

endmodule

`default_nettype wire

/* test/cpu_core_asserts.sv */
`default_nettype none

module cpu_core_asserts (
    input wire in_clk,
    input wire in_rst,
    input wire en,
    input wire uart_rx_read,
    input wire uart_tx_start
);

    // a send is a single-cycle strobe
    property tx_start_single;
        @(posedge in_clk) disable iff (in_rst)
            uart_tx_start |=> !uart_tx_start;
    endproperty

    // no receiver read from a frozen core
    property rx_read_needs_en;
        @(posedge in_clk) !en |-> !uart_rx_read;
    endproperty

    property strobes_low_after_reset;
        @(posedge in_clk) in_rst |=> (!uart_tx_start && !uart_rx_read);
    endproperty

    a_tx_start_single: assert property (tx_start_single)
        else $error("uart_tx_start high on two consecutive cycles");

    a_rx_read_needs_en: assert property (rx_read_needs_en)
        else $error("uart_rx_read high while en is low");

    a_strobes_low_after_reset: assert property (strobes_low_after_reset)
        else $error("uart strobe high in the cycle after reset");

endmodule

`default_nettype wire

/* test/cpu_core_tb.sv */
`default_nettype none

module cpu_core_tb;

    localparam int ROWS     = 6;
    localparam int MAX_PROG = 12;
    localparam int MAX_TX   = 4;
    localparam int TIMEOUT  = 400;

    localparam logic [1:0] LE_SEL = 2'(core_cfg_pkg::FLAG_LE);

    logic                                in_clk;
    logic                                in_rst;
    logic                                en;
    logic                                flash_signal;
    logic [core_cfg_pkg::PC_WIDTH-1:0]   flash_addr;
    logic [isa_pkg::CMD_WIDTH-1:0]       flash_command;
    logic                                uart_rx_empty;
    logic [core_cfg_pkg::DATA_WIDTH-1:0] uart_rx_data;
    logic                                uart_tx_done;
    logic                                uart_rx_read;
    logic                                uart_tx_start;
    logic [core_cfg_pkg::DATA_WIDTH-1:0] uart_tx_data;

    // test table, one row per program
    logic [isa_pkg::CMD_WIDTH-1:0] prog [ROWS][MAX_PROG];
    int                            prog_len [ROWS];
    logic [7:0]                    rx_byte [ROWS];
    logic [7:0]                    exp_tx [ROWS][MAX_TX];
    int                            exp_count [ROWS];
    int                            exp_reads [ROWS];
    int                            pause_after [ROWS];
    string                         row_name [ROWS];

    logic [7:0] tx_q [$];
    int         rx_reads;
    int         test_errors;
    int         total_errors;
    int         tests_failed;

    cpu_core DUT (
        .in_clk        (in_clk),
        .in_rst        (in_rst),
        .en            (en),
        .flash_signal  (flash_signal),
        .flash_addr    (flash_addr),
        .flash_command (flash_command),
        .uart_rx_empty (uart_rx_empty),
        .uart_rx_data  (uart_rx_data),
        .uart_tx_done  (uart_tx_done),
        .uart_rx_read  (uart_rx_read),
        .uart_tx_start (uart_tx_start),
        .uart_tx_data  (uart_tx_data)
    );

    bind cpu_core cpu_core_asserts u_asserts (
        .in_clk        (in_clk),
        .in_rst        (in_rst),
        .en            (en),
        .uart_rx_read  (uart_rx_read),
        .uart_tx_start (uart_tx_start)
    );

    initial begin
        in_clk = 1'b0;
        forever #2 in_clk = ~in_clk;
    end

    // command encoders, field layout of the ISA
    function automatic logic [isa_pkg::CMD_WIDTH-1:0] cmd_regs(input logic [4:0] op,
            input logic [3:0] dst, input logic [3:0] src1, input logic [3:0] src2);
        return {op, dst, src1, src2, 7'd0};
    endfunction

    function automatic logic [isa_pkg::CMD_WIDTH-1:0] cmd_lit(input logic [4:0] op,
            input logic [3:0] dst, input logic [7:0] lit);
        return {op, dst, lit, 7'd0};
    endfunction

    function automatic logic [isa_pkg::CMD_WIDTH-1:0] cmd_jump(input logic [4:0] op,
            input logic [7:0] label, input logic [1:0] flag);
        return {op, label, flag, 9'd0};
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
            input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            test_errors++;
        end
    endtask

    task automatic add_cmd(input int r, input logic [isa_pkg::CMD_WIDTH-1:0] cmd);
        prog[r][prog_len[r]] = cmd;
        prog_len[r]++;
    endtask

    task automatic set_expect(input int r, input string name, input int count,
            input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
            input logic [7:0] b3, input int reads, input int pause, input logic [7:0] rx);
        row_name[r]    = name;
        exp_count[r]   = count;
        exp_tx[r][0]   = b0;
        exp_tx[r][1]   = b1;
        exp_tx[r][2]   = b2;
        exp_tx[r][3]   = b3;
        exp_reads[r]   = reads;
        pause_after[r] = pause;
        rx_byte[r]     = rx;
    endtask

    task automatic build_table();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] d;
        logic [7:0] sum;
        a   = 8'($urandom);
        b   = 8'($urandom);
        c   = 8'($urandom_range(1, 200));
        d   = 8'($urandom);
        sum = a + b;
        for (int r = 0; r < ROWS; r++) begin
            prog_len[r] = 0;
        end
        add_cmd(0, cmd_lit(isa_pkg::OP_MOV, 4'd1, 8'h5a));
        add_cmd(0, cmd_regs(isa_pkg::OP_USEND, 4'd1, 4'd0, 4'd0));
        add_cmd(0, cmd_jump(isa_pkg::OP_JMP, 8'd2, 2'd0));
        set_expect(0, "mov then usend", 1, 8'h5a, 8'h00, 8'h00, 8'h00, 0, 0, 8'h00);
        // r5 starts at zero, so DEC and INC both wrap
        add_cmd(1, cmd_lit(isa_pkg::OP_MOV, 4'd1, a));
        add_cmd(1, cmd_lit(isa_pkg::OP_MOV, 4'd2, b));
        add_cmd(1, cmd_regs(isa_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
        add_cmd(1, cmd_regs(isa_pkg::OP_USEND, 4'd3, 4'd0, 4'd0));
        add_cmd(1, cmd_regs(isa_pkg::OP_DEC, 4'd5, 4'd0, 4'd0));
        add_cmd(1, cmd_regs(isa_pkg::OP_USEND, 4'd5, 4'd0, 4'd0));
        add_cmd(1, cmd_regs(isa_pkg::OP_INC, 4'd5, 4'd0, 4'd0));
        add_cmd(1, cmd_regs(isa_pkg::OP_USEND, 4'd5, 4'd0, 4'd0));
        add_cmd(1, cmd_jump(isa_pkg::OP_JMP, 8'd8, 2'd0));
        set_expect(1, "add inc dec wrap", 3, sum, 8'hff, 8'h00, 8'h00, 0, 0, 8'h00);
        // DEC from one sets LE, FNJMP falls through and FJMP skips
        add_cmd(2, cmd_lit(isa_pkg::OP_MOV, 4'd1, 8'd1));
        add_cmd(2, cmd_lit(isa_pkg::OP_MOV, 4'd2, c));
        add_cmd(2, cmd_regs(isa_pkg::OP_DEC, 4'd1, 4'd0, 4'd0));
        add_cmd(2, cmd_jump(isa_pkg::OP_FNJMP, 8'd5, LE_SEL));
        add_cmd(2, cmd_regs(isa_pkg::OP_USEND, 4'd2, 4'd0, 4'd0));
        add_cmd(2, cmd_jump(isa_pkg::OP_FJMP, 8'd7, LE_SEL));
        add_cmd(2, cmd_regs(isa_pkg::OP_USEND, 4'd1, 4'd0, 4'd0));
        add_cmd(2, cmd_regs(isa_pkg::OP_INC, 4'd2, 4'd0, 4'd0));
        add_cmd(2, cmd_regs(isa_pkg::OP_USEND, 4'd2, 4'd0, 4'd0));
        add_cmd(2, cmd_jump(isa_pkg::OP_JMP, 8'd9, 2'd0));
        set_expect(2, "dec flag branches", 2, c, c + 8'd1, 8'h00, 8'h00, 0, 0, 8'h00);
        add_cmd(3, cmd_lit(isa_pkg::OP_MOV, 4'd1, 8'd3));
        add_cmd(3, cmd_lit(isa_pkg::OP_MOV, 4'd2, 8'd7));
        add_cmd(3, cmd_regs(isa_pkg::OP_CMP, 4'd0, 4'd1, 4'd2));
        add_cmd(3, cmd_jump(isa_pkg::OP_FJMP, 8'd5, LE_SEL));
        add_cmd(3, cmd_regs(isa_pkg::OP_USEND, 4'd1, 4'd0, 4'd0));
        add_cmd(3, cmd_regs(isa_pkg::OP_CMP, 4'd0, 4'd2, 4'd1));
        add_cmd(3, cmd_jump(isa_pkg::OP_FJMP, 8'd8, LE_SEL));
        add_cmd(3, cmd_regs(isa_pkg::OP_USEND, 4'd2, 4'd0, 4'd0));
        add_cmd(3, cmd_jump(isa_pkg::OP_JMP, 8'd10, 2'd0));
        add_cmd(3, cmd_regs(isa_pkg::OP_USEND, 4'd1, 4'd0, 4'd0));
        add_cmd(3, cmd_regs(isa_pkg::OP_USEND, 4'd2, 4'd0, 4'd0));
        add_cmd(3, cmd_jump(isa_pkg::OP_JMP, 8'd11, 2'd0));
        set_expect(3, "cmp and jumps", 2, 8'd7, 8'd7, 8'h00, 8'h00, 0, 0, 8'h00);
        add_cmd(4, cmd_regs(isa_pkg::OP_UGET, 4'd6, 4'd0, 4'd0));
        add_cmd(4, cmd_regs(isa_pkg::OP_USEND, 4'd6, 4'd0, 4'd0));
        add_cmd(4, cmd_regs(isa_pkg::OP_INC, 4'd6, 4'd0, 4'd0));
        add_cmd(4, cmd_regs(isa_pkg::OP_USEND, 4'd6, 4'd0, 4'd0));
        add_cmd(4, cmd_regs(isa_pkg::OP_UGET, 4'd7, 4'd0, 4'd0));
        add_cmd(4, cmd_regs(isa_pkg::OP_USEND, 4'd7, 4'd0, 4'd0));
        add_cmd(4, cmd_jump(isa_pkg::OP_JMP, 8'd6, 2'd0));
        set_expect(4, "uget echo", 3, d, d + 8'd1, d, 8'h00, 2, 0, d);
        // count r1 up to r2, en dropped after the second byte
        add_cmd(5, cmd_lit(isa_pkg::OP_MOV, 4'd1, 8'h10));
        add_cmd(5, cmd_lit(isa_pkg::OP_MOV, 4'd2, 8'h14));
        add_cmd(5, cmd_regs(isa_pkg::OP_USEND, 4'd1, 4'd0, 4'd0));
        add_cmd(5, cmd_regs(isa_pkg::OP_INC, 4'd1, 4'd0, 4'd0));
        add_cmd(5, cmd_regs(isa_pkg::OP_CMP, 4'd0, 4'd2, 4'd1));
        add_cmd(5, cmd_jump(isa_pkg::OP_FNJMP, 8'd2, LE_SEL));
        add_cmd(5, cmd_jump(isa_pkg::OP_JMP, 8'd6, 2'd0));
        set_expect(5, "en freeze", 4, 8'h10, 8'h11, 8'h12, 8'h13, 0, 2, 8'h00);
    endtask

    task automatic reset_core(input int r);
        @(posedge in_clk);
        in_rst       <= 1'b1;
        en           <= 1'b0;
        uart_rx_data <= rx_byte[r];
        repeat (16) @(posedge in_clk);
        in_rst <= 1'b0;
    endtask

    // one strobe per word, strobes must stay quiet while en is low
    task automatic flash_program(input int r);
        for (int i = 0; i < prog_len[r]; i++) begin
            @(posedge in_clk);
            flash_signal  <= 1'b1;
            flash_addr    <= (core_cfg_pkg::PC_WIDTH)'(i);
            flash_command <= prog[r][i];
            @(negedge in_clk);
            check_eq(32'(uart_tx_start), 32'd0, "uart_tx_start before en");
            check_eq(32'(uart_rx_read), 32'd0, "uart_rx_read before en");
        end
        @(posedge in_clk);
        flash_signal <= 1'b0;
        en           <= 1'b1;
    endtask

    task automatic hold_enable_low();
        @(posedge in_clk);
        en <= 1'b0;
        repeat (20) begin
            @(negedge in_clk);
            check_eq(32'(uart_tx_start), 32'd0, "uart_tx_start while en is low");
        end
        @(posedge in_clk);
        en <= 1'b1;
    endtask

    task automatic collect_bytes(input int r);
        int cycles;
        bit paused;
        cycles   = 0;
        paused   = 1'b0;
        rx_reads = 0;
        tx_q.delete();
        while (tx_q.size() < exp_count[r] && cycles < TIMEOUT) begin
            @(negedge in_clk);
            cycles++;
            if (uart_rx_read)
                rx_reads++;
            if (uart_tx_start)
                tx_q.push_back(uart_tx_data);
            if (!paused && pause_after[r] != 0 && tx_q.size() == pause_after[r]) begin
                paused = 1'b1;
                hold_enable_low();
                cycles += 20;
            end
        end
        if (tx_q.size() < exp_count[r]) begin
            $display("test %0d timed out: %0d of %0d bytes sent within %0d cycles",
                     r, tx_q.size(), exp_count[r], TIMEOUT);
            test_errors++;
        end
    endtask

    task automatic compare_results(input int r);
        for (int k = 0; k < exp_count[r]; k++) begin
            if (k < tx_q.size())
                check_eq(32'(tx_q[k]), 32'(exp_tx[r][k]), "transmitted byte");
        end
        check_eq(tx_q.size(), exp_count[r], "transmitted byte count");
        check_eq(rx_reads, exp_reads[r], "uart_rx_read pulses");
    endtask

    initial begin
        in_rst        <= 1'b1;
        en            <= 1'b0;
        flash_signal  <= 1'b0;
        flash_addr    <= '0;
        flash_command <= '0;
        uart_rx_empty <= 1'b0;
        uart_rx_data  <= '0;
        uart_tx_done  <= 1'b1;
        total_errors = 0;
        tests_failed = 0;
        void'($urandom(32'h24b1c60a));
        build_table();
        for (int r = 0; r < ROWS; r++) begin
            test_errors = 0;
            reset_core(r);
            flash_program(r);
            collect_bytes(r);
            compare_results(r);
            if (test_errors == 0) begin
                $display("test %0d %s: pass", r, row_name[r]);
            end else begin
                $display("test %0d %s: FAIL with %0d errors", r, row_name[r], test_errors);
                tests_failed++;
            end
            total_errors += test_errors;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 ROWS, ROWS - tests_failed, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
source/core_cfg_pkg.sv
source/isa_pkg.sv
source/program_mem.sv
source/instr_sequencer.sv
source/execute_unit.sv
source/reg_file.sv
source/cpu_core.sv
test/cpu_core_asserts.sv
test/cpu_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
